/* vliw_core.f */
common/vliw_pkg.sv
common/vliw_map_pkg.sv
regfile/result_bank.sv
verilog/execute_stage.sv
verilog/z_arbiter.sv
verilog/vliw_core.sv
verif/tb_vliw_core.sv

/* Makefile */
# Verilator build for the vliw core and its testbench

VERILATOR ?= verilator
FILELIST  ?= vliw_core.f
TOP       ?= tb_vliw_core
RTL_TOP   ?= vliw_core
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_vliw_core
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_vliw_core.sv */
// ==============================
// vliw core testbench
// directed lane tests checked against z_value
// ==============================

`timescale 1ns/1ps

module tb_vliw_core;

   // per-test lengths in cycles with reset first
   localparam int test_len_sum = 6 + 1 + 3 + 15 + 15 + 9 + 9;
   localparam int cycle_limit  = 2 * test_len_sum;

   logic            clk;
   logic            reset;
   logic            load_enable;
   vliw_pkg::word_t load_value;
   vliw_pkg::addr_t load_dest_addr;
   logic            neg_enable;
   vliw_pkg::addr_t neg_src_addr;
   vliw_pkg::addr_t neg_dest_addr;
   logic            add_enable;
   vliw_pkg::addr_t add_src1_addr;
   vliw_pkg::addr_t add_src2_addr;
   vliw_pkg::addr_t add_dest_addr;
   vliw_pkg::word_t z_value;

   logic [15:0]     lfsr_state;
   int              cycle_count;

   vliw_core u_dut (
      .clk            (clk),
      .reset          (reset),
      .load_enable    (load_enable),
      .load_value     (load_value),
      .load_dest_addr (load_dest_addr),
      .neg_enable     (neg_enable),
      .neg_src_addr   (neg_src_addr),
      .neg_dest_addr  (neg_dest_addr),
      .add_enable     (add_enable),
      .add_src1_addr  (add_src1_addr),
      .add_src2_addr  (add_src2_addr),
      .add_dest_addr  (add_dest_addr),
      .z_value        (z_value)
   );

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ==============================
   // helpers
   // ==============================

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output vliw_pkg::word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[vliw_pkg::word_width-2:0], lfsr_state[15]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // bank field on top, entry index below
   function automatic vliw_pkg::addr_t addr_of(input logic [1:0] bank, input logic [7:0] index);
      return {bank, index};
   endfunction

   task automatic check_value(input string name, input vliw_pkg::word_t got,
                              input vliw_pkg::word_t expected);
      if (got !== expected) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, expected);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // lane setters used between begin_cycle and end_cycle
   task automatic load_slot(input vliw_pkg::addr_t dest, input vliw_pkg::word_t value);
      load_enable    <= 1'b1;
      load_value     <= value;
      load_dest_addr <= dest;
   endtask

   task automatic neg_slot(input vliw_pkg::addr_t src, input vliw_pkg::addr_t dest);
      neg_enable    <= 1'b1;
      neg_src_addr  <= src;
      neg_dest_addr <= dest;
   endtask

   task automatic add_slot(input vliw_pkg::addr_t src1, input vliw_pkg::addr_t src2,
                           input vliw_pkg::addr_t dest);
      add_enable    <= 1'b1;
      add_src1_addr <= src1;
      add_src2_addr <= src2;
      add_dest_addr <= dest;
   endtask

   task automatic begin_cycle();
      @(posedge clk);
   endtask

   // enables drop after one cycle and the result lands on this edge
   task automatic end_cycle();
      @(posedge clk);
      load_enable <= 1'b0;
      neg_enable  <= 1'b0;
      add_enable  <= 1'b0;
      @(negedge clk);
   endtask

   // ==============================
   // directed tests
   // ==============================

   task automatic reset_state();
      @(negedge clk);
      check_value("z_value after reset", z_value, '0);
   endtask

   task automatic load_into_z();
      vliw_pkg::word_t a;
      rand_bits(vliw_pkg::word_width, a);
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h00), a);
      end_cycle();
      check_value("z_value load", z_value, a);
   endtask

   task automatic negate_via_bank();
      vliw_pkg::word_t a;
      vliw_pkg::word_t b;
      vliw_pkg::word_t k;
      rand_bits(vliw_pkg::word_width, a);
      rand_bits(vliw_pkg::word_width, b);
      rand_bits(8, k);
      // index 0 would hit z
      if (k[7:0] == 8'h00) begin
         k = 27'h5a;
      end
      begin_cycle();
      load_slot(addr_of(2'd0, k[7:0]), a);
      end_cycle();
      begin_cycle();
      neg_slot(addr_of(2'd0, k[7:0]), addr_of(2'd0, 8'h00));
      end_cycle();
      check_value("z_value negate", z_value, ~a + 27'd1);
      // second pass parks the result in bank 1
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h17), b);
      end_cycle();
      begin_cycle();
      neg_slot(addr_of(2'd0, 8'h17), addr_of(2'd1, 8'h29));
      end_cycle();
      begin_cycle();
      neg_slot(addr_of(2'd1, 8'h29), addr_of(2'd0, 8'h00));
      end_cycle();
      check_value("z_value double negate", z_value, ~(~b + 27'd1) + 27'd1);
   endtask

   task automatic add_into_z();
      vliw_pkg::word_t a;
      vliw_pkg::word_t b;
      rand_bits(vliw_pkg::word_width, a);
      rand_bits(vliw_pkg::word_width, b);
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h00), '0);
      end_cycle();
      check_value("z_value cleared", z_value, '0);
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h11), a);
      end_cycle();
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h22), b);
      end_cycle();
      begin_cycle();
      add_slot(addr_of(2'd0, 8'h11), addr_of(2'd0, 8'h22), addr_of(2'd2, 8'h33));
      end_cycle();
      // zero-valued z as second operand
      begin_cycle();
      add_slot(addr_of(2'd2, 8'h33), addr_of(2'd1, 8'h00), addr_of(2'd0, 8'h00));
      end_cycle();
      check_value("z_value add", z_value, a + b);
   endtask

   task automatic z_priority();
      vliw_pkg::word_t c;
      vliw_pkg::word_t v;
      rand_bits(vliw_pkg::word_width, c);
      rand_bits(vliw_pkg::word_width, v);
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h5c), c);
      end_cycle();
      // load beats negate
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h00), v);
      neg_slot(addr_of(2'd0, 8'h5c), addr_of(2'd1, 8'h00));
      end_cycle();
      check_value("z_value load over negate", z_value, v);
      // negate beats add
      begin_cycle();
      neg_slot(addr_of(2'd0, 8'h5c), addr_of(2'd1, 8'h00));
      add_slot(addr_of(2'd0, 8'h5c), addr_of(2'd0, 8'h5c), addr_of(2'd2, 8'h00));
      end_cycle();
      check_value("z_value negate over add", z_value, ~c + 27'd1);
   endtask

   task automatic map_edges();
      vliw_pkg::word_t d;
      rand_bits(vliw_pkg::word_width, d);
      // reserved bank reads as zero
      begin_cycle();
      neg_slot(addr_of(2'd3, 8'h42), addr_of(2'd0, 8'h00));
      end_cycle();
      check_value("z_value bank 3 read", z_value, '0);
      begin_cycle();
      load_slot(addr_of(2'd0, 8'h00), d);
      end_cycle();
      // index 0 of bank 2 is z itself
      begin_cycle();
      neg_slot(addr_of(2'd2, 8'h00), addr_of(2'd0, 8'h00));
      end_cycle();
      check_value("z_value negate z", z_value, ~d + 27'd1);
   endtask

   // ==============================
   // run control
   // ==============================

   initial begin
      cycle_count = 0;
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("CHECKS FAILED");
      $fatal(1, "timeout after %0d cycles, the tests did not finish", cycle_count);
   end

   initial begin
      lfsr_state = 16'd21;
      reset          <= 1'b1;
      load_enable    <= 1'b0;
      load_value     <= '0;
      load_dest_addr <= '0;
      neg_enable     <= 1'b0;
      neg_src_addr   <= '0;
      neg_dest_addr  <= '0;
      add_enable     <= 1'b0;
      add_src1_addr  <= '0;
      add_src2_addr  <= '0;
      add_dest_addr  <= '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      reset_state();
      load_into_z();
      negate_via_bank();
      add_into_z();
      z_priority();
      map_edges();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* verilog/vliw_core.sv */
// ==============================
// vliw core top level
// load, negate and add lanes around three banks and z
// ==============================

`timescale 1ns/1ps

module vliw_core (
   input  logic             clk,
   input  logic             reset,
   // load lane
   input  logic             load_enable,
   input  vliw_pkg::word_t  load_value,
   input  vliw_pkg::addr_t  load_dest_addr,
   // negate lane
   input  logic             neg_enable,
   input  vliw_pkg::addr_t  neg_src_addr,
   input  vliw_pkg::addr_t  neg_dest_addr,
   // add lane
   input  logic             add_enable,
   input  vliw_pkg::addr_t  add_src1_addr,
   input  vliw_pkg::addr_t  add_src2_addr,
   input  vliw_pkg::addr_t  add_dest_addr,
   // shared z register
   output vliw_pkg::word_t  z_value
);

   // read indices, shared by all three banks
   vliw_pkg::index_t src_index [vliw_map_pkg::num_read_ports];

   // read words coming back from each bank
   vliw_pkg::word_t  load_rd [vliw_map_pkg::num_read_ports];
   vliw_pkg::word_t  neg_rd  [vliw_map_pkg::num_read_ports];
   vliw_pkg::word_t  add_rd  [vliw_map_pkg::num_read_ports];

   // bank write side per lane
   logic             load_we;
   logic             neg_we;
   logic             add_we;
   vliw_pkg::index_t load_wr_index;
   vliw_pkg::index_t neg_wr_index;
   vliw_pkg::index_t add_wr_index;
   vliw_pkg::word_t  load_result;
   vliw_pkg::word_t  neg_result;
   vliw_pkg::word_t  add_result;

   // z write requests per lane
   logic             load_z_req;
   logic             neg_z_req;
   logic             add_z_req;

   // ==============================
   // execute
   // ==============================

   execute_stage u_execute (
      .load_enable    (load_enable),
      .load_value     (load_value),
      .load_dest_addr (load_dest_addr),
      .neg_enable     (neg_enable),
      .neg_src_addr   (neg_src_addr),
      .neg_dest_addr  (neg_dest_addr),
      .add_enable     (add_enable),
      .add_src1_addr  (add_src1_addr),
      .add_src2_addr  (add_src2_addr),
      .add_dest_addr  (add_dest_addr),
      .z_value        (z_value),
      .load_rd        (load_rd),
      .neg_rd         (neg_rd),
      .add_rd         (add_rd),
      .src_index      (src_index),
      .load_we        (load_we),
      .neg_we         (neg_we),
      .add_we         (add_we),
      .load_wr_index  (load_wr_index),
      .neg_wr_index   (neg_wr_index),
      .add_wr_index   (add_wr_index),
      .load_result    (load_result),
      .neg_result     (neg_result),
      .add_result     (add_result),
      .load_z_req     (load_z_req),
      .neg_z_req      (neg_z_req),
      .add_z_req      (add_z_req)
   );

   // ==============================
   // result banks
   // ==============================

   // bank 0, written by load
   result_bank u_load_bank (
      .clk      (clk),
      .we       (load_we),
      .wr_index (load_wr_index),
      .wr_data  (load_result),
      .rd_index (src_index),
      .rd_data  (load_rd)
   );

   // bank 1, written by negate
   result_bank u_neg_bank (
      .clk      (clk),
      .we       (neg_we),
      .wr_index (neg_wr_index),
      .wr_data  (neg_result),
      .rd_index (src_index),
      .rd_data  (neg_rd)
   );

   // bank 2, written by add
   result_bank u_add_bank (
      .clk      (clk),
      .we       (add_we),
      .wr_index (add_wr_index),
      .wr_data  (add_result),
      .rd_index (src_index),
      .rd_data  (add_rd)
   );

   // z register, load beats negate beats add
   z_arbiter u_z_arbiter (
      .clk         (clk),
      .reset       (reset),
      .load_z_req  (load_z_req),
      .neg_z_req   (neg_z_req),
      .add_z_req   (add_z_req),
      .load_result (load_result),
      .neg_result  (neg_result),
      .add_result  (add_result),
      .z_value     (z_value)
   );

endmodule

/* verilog/z_arbiter.sv */
// ==============================
// z register
// fixed priority load, negate, add
// ==============================

`timescale 1ns/1ps

module z_arbiter (
   input  logic            clk,
   input  logic            reset,
   // write requests, already gated on index 0
   input  logic            load_z_req,
   input  logic            neg_z_req,
   input  logic            add_z_req,
   // lane results
   input  vliw_pkg::word_t load_result,
   input  vliw_pkg::word_t neg_result,
   input  vliw_pkg::word_t add_result,
   // current z
   output vliw_pkg::word_t z_value
);

   vliw_pkg::word_t z_reg;

   // ==============================
   // arbitration
   // ==============================

   // load wins over negate, negate over add
   // no request keeps the old z
   always_ff @(posedge clk) begin
      if (reset) begin
         z_reg <= '0;
      end else if (load_z_req) begin
         z_reg <= load_result;
      end else if (neg_z_req) begin
         z_reg <= neg_result;
      end else if (add_z_req) begin
         z_reg <= add_result;
      end
   end

   // straight from the flop, readers see pre-edge z
   assign z_value = z_reg;

endmodule

/* verilog/execute_stage.sv */
// ==============================
// vliw execute stage
// operand muxing, negate and add, write steering
// ==============================

`timescale 1ns/1ps

module execute_stage (
   input  logic             load_enable,
   input  vliw_pkg::word_t  load_value,
   input  vliw_pkg::addr_t  load_dest_addr,
   input  logic             neg_enable,
   input  vliw_pkg::addr_t  neg_src_addr,
   input  vliw_pkg::addr_t  neg_dest_addr,
   input  logic             add_enable,
   input  vliw_pkg::addr_t  add_src1_addr,
   input  vliw_pkg::addr_t  add_src2_addr,
   input  vliw_pkg::addr_t  add_dest_addr,
   input  vliw_pkg::word_t  z_value,
   // read words from bank 0, 1 and 2
   input  vliw_pkg::word_t  load_rd [vliw_map_pkg::num_read_ports],
   input  vliw_pkg::word_t  neg_rd  [vliw_map_pkg::num_read_ports],
   input  vliw_pkg::word_t  add_rd  [vliw_map_pkg::num_read_ports],
   output vliw_pkg::index_t src_index [vliw_map_pkg::num_read_ports],
   // bank writes
   output logic             load_we,
   output logic             neg_we,
   output logic             add_we,
   output vliw_pkg::index_t load_wr_index,
   output vliw_pkg::index_t neg_wr_index,
   output vliw_pkg::index_t add_wr_index,
   output vliw_pkg::word_t  load_result,
   output vliw_pkg::word_t  neg_result,
   output vliw_pkg::word_t  add_result,
   // z writes
   output logic             load_z_req,
   output logic             neg_z_req,
   output logic             add_z_req
);

   // operand from z, a bank, or zero for the reserved bank
   function automatic vliw_pkg::word_t pick_operand(
      input vliw_pkg::addr_t addr,
      input vliw_pkg::word_t z,
      input vliw_pkg::word_t from_load,
      input vliw_pkg::word_t from_neg,
      input vliw_pkg::word_t from_add
   );
      vliw_map_pkg::bank_sel_t bank;
      vliw_pkg::word_t         operand;
      bank = addr[vliw_pkg::addr_width-1:vliw_pkg::index_width];
      case (bank)
         vliw_map_pkg::bank_load: operand = from_load;
         vliw_map_pkg::bank_neg:  operand = from_neg;
         vliw_map_pkg::bank_add:  operand = from_add;
         vliw_map_pkg::bank_mul:  operand = '0;
      endcase
      // index 0 overrides the bank field in every bank
      if (addr[vliw_pkg::index_width-1:0] == vliw_map_pkg::z_index) begin
         operand = z;
      end
      return operand;
   endfunction

   vliw_pkg::word_t neg_src;
   vliw_pkg::word_t add_src1;
   vliw_pkg::word_t add_src2;

   // ==============================
   // operand reads
   // ==============================

   // low bits of each source go to every bank, the mux picks one
   assign src_index[vliw_map_pkg::port_neg_src]  = neg_src_addr[vliw_pkg::index_width-1:0];
   assign src_index[vliw_map_pkg::port_add_src1] = add_src1_addr[vliw_pkg::index_width-1:0];
   assign src_index[vliw_map_pkg::port_add_src2] = add_src2_addr[vliw_pkg::index_width-1:0];

   assign neg_src  = pick_operand(neg_src_addr, z_value,
                                  load_rd[vliw_map_pkg::port_neg_src],
                                  neg_rd[vliw_map_pkg::port_neg_src],
                                  add_rd[vliw_map_pkg::port_neg_src]);
   assign add_src1 = pick_operand(add_src1_addr, z_value,
                                  load_rd[vliw_map_pkg::port_add_src1],
                                  neg_rd[vliw_map_pkg::port_add_src1],
                                  add_rd[vliw_map_pkg::port_add_src1]);
   assign add_src2 = pick_operand(add_src2_addr, z_value,
                                  load_rd[vliw_map_pkg::port_add_src2],
                                  neg_rd[vliw_map_pkg::port_add_src2],
                                  add_rd[vliw_map_pkg::port_add_src2]);

   // two's complement and sum, both wrap at 27 bits
   assign load_result = load_value;
   assign neg_result  = -neg_src;
   assign add_result  = add_src1 + add_src2;

   // dest bank field is implied by the lane, only the index matters
   assign load_wr_index = load_dest_addr[vliw_pkg::index_width-1:0];
   assign neg_wr_index  = neg_dest_addr[vliw_pkg::index_width-1:0];
   assign add_wr_index  = add_dest_addr[vliw_pkg::index_width-1:0];

   // index 0 goes to z only, everything else to the own bank
   assign load_z_req = load_enable && (load_wr_index == vliw_map_pkg::z_index);
   assign neg_z_req  = neg_enable  && (neg_wr_index  == vliw_map_pkg::z_index);
   assign add_z_req  = add_enable  && (add_wr_index  == vliw_map_pkg::z_index);
   assign load_we    = load_enable && (load_wr_index != vliw_map_pkg::z_index);
   assign neg_we     = neg_enable  && (neg_wr_index  != vliw_map_pkg::z_index);
   assign add_we     = add_enable  && (add_wr_index  != vliw_map_pkg::z_index);

endmodule

/* regfile/result_bank.sv */
// ==============================
// result bank
// 256 words, one write port, three async read ports
// ==============================

`timescale 1ns/1ps

module result_bank (
   input  logic             clk,
   // write port, owned by one lane
   input  logic             we,
   input  vliw_pkg::index_t wr_index,
   input  vliw_pkg::word_t  wr_data,
   // read ports, one per operand
   input  vliw_pkg::index_t rd_index [vliw_map_pkg::num_read_ports],
   output vliw_pkg::word_t  rd_data  [vliw_map_pkg::num_read_ports]
);

   // ==============================
   // storage
   // ==============================

   // entry 0 is never written, z covers that index
   vliw_pkg::word_t mem [vliw_pkg::bank_depth];

   // write lands on the edge
   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_index] <= wr_data;
      end
   end

   // ==============================
   // reads
   // ==============================

   // combinational, so a same-cycle write is not seen yet
   always_comb begin
      for (int p = 0; p < vliw_map_pkg::num_read_ports; p++) begin
         rd_data[p] = mem[rd_index[p]];
      end
   end

endmodule

/* common/vliw_map_pkg.sv */
// ==============================
// vliw address map
// bank ids, z index and read-port numbering
// ==============================

package vliw_map_pkg;

   // bank field is what is left above the entry index
   typedef logic [vliw_pkg::addr_width-vliw_pkg::index_width-1:0] bank_sel_t;

   // ==============================
   // bank ids
   // ==============================

   // one bank per writing lane
   localparam bank_sel_t bank_load = bank_sel_t'(0);
   localparam bank_sel_t bank_neg  = bank_sel_t'(1);
   localparam bank_sel_t bank_add  = bank_sel_t'(2);
   // reserved, no lane writes here, reads give zero
   localparam bank_sel_t bank_mul  = bank_sel_t'(3);

   // entry 0 of any bank maps onto the shared z register
   localparam vliw_pkg::index_t z_index = '0;

   // ==============================
   // read ports
   // ==============================

   // every bank serves the same three operand reads
   localparam int num_read_ports = 3;

   localparam int port_neg_src  = 0;
   localparam int port_add_src1 = 1;
   localparam int port_add_src2 = 2;

endpackage

/* common/vliw_pkg.sv */
// ==============================
// vliw shared data types
// word, address and index widths for all lanes
// ==============================

package vliw_pkg;

   // ==============================
   // data word
   // ==============================

   // 27-bit datapath, add and negate wrap at this width
   localparam int word_width = 27;

   typedef logic [word_width-1:0] word_t;

   // ==============================
   // lane addressing
   // ==============================

   // full lane address, bank field on top of the entry index
   localparam int addr_width = 10;

   typedef logic [addr_width-1:0] addr_t;

   // entry index inside one bank
   localparam int index_width = 8;

   typedef logic [index_width-1:0] index_t;

   // entries per bank, one per index value
   localparam int bank_depth = 1 << index_width;

endpackage
